// File: verilog/backend_cfg.svh
// data width, register count and register index width
// for the in-order back end

`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

`define BE_XLEN 32

`define BE_NREG 8

`define BE_RAW 3

`endif

// File: verilog/backend_pkg.sv
// opcode enumeration and micro-instruction word
// shared by dispatch, execute and the testbench

`include "backend_cfg.svh"

package backend_pkg;

	// bit 3 set marks the immediate form
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_ADDI = 4'd8,
		OP_LUI  = 4'd9
	} alu_op_e;

	// op, rd and rs1 sit in the same place in both forms
	typedef union packed {
		struct packed {
			alu_op_e                       op;
			logic [`BE_RAW-1:0]            rd;
			logic [`BE_RAW-1:0]            rs1;
			logic [`BE_RAW-1:0]            rs2;
			logic [`BE_XLEN-4-3*`BE_RAW-1:0] pad;
		} r_form;
		struct packed {
			alu_op_e                          op;
			logic [`BE_RAW-1:0]               rd;
			logic [`BE_RAW-1:0]               rs1;
			logic [`BE_XLEN-4-2*`BE_RAW-17:0] pad;
			logic signed [15:0]               imm;
		} i_form;
	} micro_instr_u;

endpackage

// File: verilog/backend_if.sv
// exe_if carries the issued operation from dispatch to execute
// wb_if carries the result and the register file read ports

`timescale 1ns/1ps

`include "backend_cfg.svh"

interface exe_if;
	import backend_pkg::*;

	logic               valid;
	alu_op_e            op;
	logic [`BE_RAW-1:0] rd;
	logic [`BE_XLEN-1:0] src_a;
	logic [`BE_XLEN-1:0] src_b;

	modport issue (output valid, op, rd, src_a, src_b);
	modport exe (input valid, op, rd, src_a, src_b);
endinterface

interface wb_if;
	logic                wb_valid;
	logic [`BE_RAW-1:0]  wb_rd;
	logic [`BE_XLEN-1:0] wb_data;

	// two combinational read ports into the register file
	logic [`BE_RAW-1:0]  rs1_addr;
	logic [`BE_RAW-1:0]  rs2_addr;
	logic [`BE_XLEN-1:0] rs1_data;
	logic [`BE_XLEN-1:0] rs2_data;

	modport src (output wb_valid, wb_rd, wb_data);
	modport rd (
		output rs1_addr, rs2_addr,
		input  rs1_data, rs2_data, wb_valid, wb_rd
	);
	modport rf (
		input  wb_valid, wb_rd, wb_data, rs1_addr, rs2_addr,
		output rs1_data, rs2_data
	);
endinterface

// File: verilog/dispatch.sv
// decode stage of the back end
// pops the instruction FIFO, checks the busy scoreboard,
// reads operands and registers the issue to execute

`timescale 1ns/1ps

`include "backend_cfg.svh"

module dispatch (
	input  logic                      CLK,
	input  logic                      i_rst,
	input  backend_pkg::micro_instr_u i_instr,
	input  logic                      i_instr_empty,
	output logic                      o_instr_pop,
	exe_if.issue                      exe,
	wb_if.rd                          wb
);
	import backend_pkg::*;

	alu_op_e             op;
	logic [`BE_RAW-1:0]  rd;
	logic [`BE_RAW-1:0]  rs1;
	logic [`BE_RAW-1:0]  rs2;
	logic [15:0]         imm;
	logic                is_imm;
	logic                is_lui;

	logic [`BE_NREG-1:0] busy;
	logic [`BE_NREG-1:0] busy_nxt;
	logic                rs1_hit;
	logic                rs2_hit;
	logic                rd_hit;

	logic [`BE_XLEN-1:0] src_a;
	logic [`BE_XLEN-1:0] src_b;

	// fields common to both forms come from the register view
	assign op     = i_instr.r_form.op;
	assign rd     = i_instr.r_form.rd;
	assign rs1    = i_instr.r_form.rs1;
	assign rs2    = i_instr.r_form.rs2;
	assign imm    = i_instr.i_form.imm;
	assign is_imm = op[3];
	assign is_lui = (op == OP_LUI);

	assign wb.rs1_addr = rs1;
	assign wb.rs2_addr = rs2;

	// lui reads no register and immediates read no rs2
	assign rs1_hit = !is_lui && busy[rs1];
	assign rs2_hit = !is_imm && busy[rs2];
	assign rd_hit  = busy[rd];

	assign o_instr_pop = !i_instr_empty && !rs1_hit && !rs2_hit && !rd_hit;

	// operand build
	always_comb begin
		src_a = is_lui ? '0 : wb.rs1_data;
		case (op)
			OP_ADDI: src_b = {{(`BE_XLEN-16){imm[15]}}, imm};
			OP_LUI:  src_b = {imm, {(`BE_XLEN-16){1'b0}}};
			default: src_b = wb.rs2_data;
		endcase
	end

	// writeback clears a busy bit and issue sets one
	always_comb begin
		busy_nxt = busy;
		if (wb.wb_valid)
			busy_nxt[wb.wb_rd] = 1'b0;
		if (o_instr_pop)
			busy_nxt[rd] = 1'b1;
		// r0 is never busy
		busy_nxt[0] = 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			busy      <= '0;
			exe.valid <= 1'b0;
		end else begin
			busy      <= busy_nxt;
			exe.valid <= o_instr_pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_instr_pop) begin
			exe.op    <= op;
			exe.rd    <= rd;
			exe.src_a <= src_a;
			exe.src_b <= src_b;
		end
	end

	// a result only ever returns to a register marked busy
	a_wb_clears_busy: assert property (
		@(posedge CLK) disable iff (i_rst)
		(wb.wb_valid && wb.wb_rd != '0) |-> busy[wb.wb_rd]
	);

	a_pop_legal_op: assert property (
		@(posedge CLK) disable iff (i_rst)
		o_instr_pop |-> op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
			OP_XOR, OP_SLL, OP_ADDI, OP_LUI}
	);

endmodule

// File: verilog/alu_exe.sv
// execute stage
// one-cycle registered ALU for the register and immediate forms

`timescale 1ns/1ps

`include "backend_cfg.svh"

module alu_exe (
	input logic CLK,
	input logic i_rst,
	exe_if.exe  exe,
	wb_if.src   wb
);
	import backend_pkg::*;

	logic [`BE_XLEN-1:0] result;

	// lui arrives with src_a forced to zero, so it shares the adder
	always_comb begin
		case (exe.op)
			OP_ADD,
			OP_ADDI,
			OP_LUI:  result = exe.src_a + exe.src_b;
			OP_SUB:  result = exe.src_a - exe.src_b;
			OP_AND:  result = exe.src_a & exe.src_b;
			OP_OR:   result = exe.src_a | exe.src_b;
			OP_XOR:  result = exe.src_a ^ exe.src_b;
			OP_SLL:  result = exe.src_a << exe.src_b[4:0];
			default: result = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_rst)
			wb.wb_valid <= 1'b0;
		else
			wb.wb_valid <= exe.valid;
	end

	// result payload
	always_ff @(posedge CLK) begin
		if (exe.valid) begin
			wb.wb_rd   <= exe.rd;
			wb.wb_data <= result;
		end
	end

	// issue payload has no reset, so it must be set by the time it is used
	a_issue_known: assert property (
		@(posedge CLK) disable iff (i_rst)
		exe.valid |-> !$isunknown({exe.op, exe.rd, exe.src_a, exe.src_b})
	);

endmodule

// File: verilog/writeback.sv
// result stage
// architectural register file with two combinational read ports,
// register 0 reads as zero

`timescale 1ns/1ps

`include "backend_cfg.svh"

module writeback (
	input logic CLK,
	input logic i_rst,
	wb_if.rf    wb
);

	logic [`BE_XLEN-1:0] regs [0:`BE_NREG-1];
	logic                wr_en;

	// writes to r0 are reported but dropped here
	assign wr_en = wb.wb_valid && (wb.wb_rd != '0);

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			for (int i = 0; i < `BE_NREG; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.wb_rd] <= wb.wb_data;
		end
	end

	// read ports
	assign wb.rs1_data = (wb.rs1_addr == '0) ? '0 : regs[wb.rs1_addr];
	assign wb.rs2_data = (wb.rs2_addr == '0) ? '0 : regs[wb.rs2_addr];

	a_wb_rd_known: assert property (
		@(posedge CLK) disable iff (i_rst)
		wb.wb_valid |-> !$isunknown(wb.wb_rd)
	);

endmodule

// File: verilog/backend.sv
// top level of the in-order back end
// dispatch, registered ALU and writeback joined by exe_if and wb_if

`timescale 1ns/1ps

`include "backend_cfg.svh"

module backend (
	input  logic                CLK,
	input  logic                i_rst,

	// instruction FIFO
	input  logic [`BE_XLEN-1:0] i_instr,
	input  logic                i_instr_empty,
	output logic                o_instr_pop,

	// writeback stream
	output logic                o_wb_valid,
	output logic [`BE_RAW-1:0]  o_wb_rd,
	output logic [`BE_XLEN-1:0] o_wb_data
);

	exe_if u_exe_if ();
	wb_if  u_wb_if ();

	dispatch u_dispatch (
		.CLK           (CLK),
		.i_rst         (i_rst),
		.i_instr       (i_instr),
		.i_instr_empty (i_instr_empty),
		.o_instr_pop   (o_instr_pop),
		.exe           (u_exe_if.issue),
		.wb            (u_wb_if.rd)
	);

	alu_exe u_alu_exe (
		.CLK   (CLK),
		.i_rst (i_rst),
		.exe   (u_exe_if.exe),
		.wb    (u_wb_if.src)
	);

	writeback u_writeback (
		.CLK   (CLK),
		.i_rst (i_rst),
		.wb    (u_wb_if.rf)
	);

	assign o_wb_valid = u_wb_if.wb_valid;
	assign o_wb_rd    = u_wb_if.wb_rd;
	assign o_wb_data  = u_wb_if.wb_data;

endmodule

// File: bench/backend_check.sv
// checking module for the back end testbench
// reference model, expected writeback queue, comparison and counts

`timescale 1ns/1ps

`include "backend_cfg.svh"

module backend_check (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  backend_pkg::micro_instr_u i_instr,
	input  logic                      i_instr_empty,
	input  logic                      i_instr_pop,
	input  logic                      i_wb_valid,
	input  logic [`BE_RAW-1:0]        i_wb_rd,
	input  logic [`BE_XLEN-1:0]       i_wb_data,
	output int                        o_outstanding,
	output int                        o_pops,
	output int                        o_wbs,
	output int                        o_errors
);
	import backend_pkg::*;

	typedef struct packed {
		logic [`BE_RAW-1:0]  rd;
		logic [`BE_XLEN-1:0] data;
		int                  pop_cycle;
	} expect_t;

	expect_t             exp_q [$];
	expect_t             head;
	expect_t             item;
	logic [`BE_XLEN-1:0] model_rf [0:`BE_NREG-1];
	int                  cycle;

	// result of one word from the decode rules
	function automatic logic [`BE_XLEN-1:0] expected_value(input micro_instr_u w,
		input logic [`BE_XLEN-1:0] a, input logic [`BE_XLEN-1:0] b);
		logic [`BE_XLEN-1:0] simm;
		logic [`BE_XLEN-1:0] res;
		simm = {{(`BE_XLEN-16){w.i_form.imm[15]}}, w.i_form.imm};
		case (w.r_form.op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SLL:  res = a << b[4:0];
			OP_ADDI: res = a + simm;
			OP_LUI:  res = {w.i_form.imm, {(`BE_XLEN-16){1'b0}}};
			default: res = '0;
		endcase
		return res;
	endfunction

	always @(posedge i_clk) begin
		if (i_rst) begin
			exp_q.delete();
			for (int i = 0; i < `BE_NREG; i++)
				model_rf[i] = '0;
			cycle = 0;
		end else begin
			cycle = cycle + 1;
			if (i_wb_valid) begin
				o_wbs = o_wbs + 1;
				if (exp_q.size() == 0) begin
					$display("t=%0t: writeback to r%0d arrived with nothing outstanding",
						$time, i_wb_rd);
					o_errors = o_errors + 1;
				end else begin
					head = exp_q.pop_front();
					if (i_wb_rd !== head.rd) begin
						$display("ERR t=%0t o_wb_rd expected %0d got %0d",
							$time, head.rd, i_wb_rd);
						o_errors = o_errors + 1;
					end
					if (i_wb_data !== head.data) begin
						$display("ERR t=%0t o_wb_data expected %h got %h",
							$time, head.data, i_wb_data);
						o_errors = o_errors + 1;
					end
					if (cycle - head.pop_cycle != 2) begin
						$display("t=%0t: writeback came %0d cycles after its pop instead of 2",
							$time, cycle - head.pop_cycle);
						o_errors = o_errors + 1;
					end
				end
			end
			if (i_instr_pop) begin
				if (i_instr_empty) begin
					$display("t=%0t: pop asserted while the instruction FIFO is empty", $time);
					o_errors = o_errors + 1;
				end
				item.rd        = i_instr.r_form.rd;
				item.data      = expected_value(i_instr, model_rf[i_instr.r_form.rs1],
					model_rf[i_instr.r_form.rs2]);
				item.pop_cycle = cycle;
				exp_q.push_back(item);
				// r0 stays zero in the model
				if (item.rd != '0)
					model_rf[item.rd] = item.data;
				o_pops = o_pops + 1;
			end
		end
		o_outstanding = exp_q.size();
	end

endmodule

// File: bench/backend_tb.sv
// testbench top for the in-order back end
// clock, reset, instruction FIFO model, five tests and a watchdog

`timescale 1ns/1ps

`include "backend_cfg.svh"

module backend_tb;
	import backend_pkg::*;

	localparam int DIRECTED_WORDS = 33;
	localparam int GAP_WORDS      = 40;
	localparam int RAND_WORDS     = 200;
	localparam int WATCHDOG_NS    =
		((DIRECTED_WORDS + GAP_WORDS + RAND_WORDS) * 6 + 200) * 20;

	logic                CLK;
	logic                i_rst;
	logic [`BE_XLEN-1:0] i_instr;
	logic                i_instr_empty;
	logic                o_instr_pop;
	logic                o_wb_valid;
	logic [`BE_RAW-1:0]  o_wb_rd;
	logic [`BE_XLEN-1:0] o_wb_data;

	logic [`BE_XLEN-1:0] fifo_q [$];
	integer              seed = 32'h9c54_6080;
	int                  chk_outstanding;
	int                  chk_pops;
	int                  chk_wbs;
	int                  chk_errors;
	int                  bench_errors;
	int                  test_count;

	backend DUT (
		.CLK           (CLK),
		.i_rst         (i_rst),
		.i_instr       (i_instr),
		.i_instr_empty (i_instr_empty),
		.o_instr_pop   (o_instr_pop),
		.o_wb_valid    (o_wb_valid),
		.o_wb_rd       (o_wb_rd),
		.o_wb_data     (o_wb_data)
	);

	backend_check u_check (
		.i_clk         (CLK),
		.i_rst         (i_rst),
		.i_instr       (i_instr),
		.i_instr_empty (i_instr_empty),
		.i_instr_pop   (o_instr_pop),
		.i_wb_valid    (o_wb_valid),
		.i_wb_rd       (o_wb_rd),
		.i_wb_data     (o_wb_data),
		.o_outstanding (chk_outstanding),
		.o_pops        (chk_pops),
		.o_wbs         (chk_wbs),
		.o_errors      (chk_errors)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [`BE_XLEN-1:0] r_type_word(input alu_op_e op,
		input logic [`BE_RAW-1:0] rd, input logic [`BE_RAW-1:0] rs1,
		input logic [`BE_RAW-1:0] rs2);
		micro_instr_u w;
		w = '0;
		w.r_form.op  = op;
		w.r_form.rd  = rd;
		w.r_form.rs1 = rs1;
		w.r_form.rs2 = rs2;
		return w;
	endfunction

	function automatic logic [`BE_XLEN-1:0] imm_word(input alu_op_e op,
		input logic [`BE_RAW-1:0] rd, input logic [`BE_RAW-1:0] rs1, input logic [15:0] imm);
		micro_instr_u w;
		w = '0;
		w.i_form.op  = op;
		w.i_form.rd  = rd;
		w.i_form.rs1 = rs1;
		w.i_form.imm = imm;
		return w;
	endfunction

	// random fields and pad, legal opcode
	function automatic logic [`BE_XLEN-1:0] random_word();
		micro_instr_u w;
		logic [31:0]  pick;
		w    = $random(seed);
		pick = $random(seed);
		case (pick[2:0])
			3'd0: w.r_form.op = OP_ADD;
			3'd1: w.r_form.op = OP_SUB;
			3'd2: w.r_form.op = OP_AND;
			3'd3: w.r_form.op = OP_OR;
			3'd4: w.r_form.op = OP_XOR;
			3'd5: w.r_form.op = OP_SLL;
			3'd6: w.r_form.op = OP_ADDI;
			default: w.r_form.op = OP_LUI;
		endcase
		return w;
	endfunction

	// one clock of the FIFO model
	task automatic step_cycle(input bit with_gaps);
		logic [31:0] pick;
		@(posedge CLK);
		if (o_instr_pop && fifo_q.size() > 0)
			void'(fifo_q.pop_front());
		pick = $random(seed);
		if (fifo_q.size() > 0)
			i_instr <= fifo_q[0];
		else
			i_instr <= '0;
		i_instr_empty <= (fifo_q.size() == 0) || (with_gaps && pick[0]);
	endtask

	task automatic run_queue(input string name, input bit with_gaps);
		int words;
		int pops_before;
		int wbs_before;
		int errs_before;
		words       = fifo_q.size();
		pops_before = chk_pops;
		wbs_before  = chk_wbs;
		errs_before = chk_errors + bench_errors;
		while (fifo_q.size() > 0)
			step_cycle(with_gaps);
		@(negedge CLK);
		while (chk_outstanding != 0)
			@(negedge CLK);
		// idle cycles to catch a stray writeback
		repeat (3) @(negedge CLK);
		if (chk_pops - pops_before != words) begin
			$display("%s: %0d words queued but %0d popped", name, words,
				chk_pops - pops_before);
			bench_errors++;
		end
		if (chk_wbs - wbs_before != chk_pops - pops_before) begin
			$display("%s: %0d pops but %0d writebacks", name, chk_pops - pops_before,
				chk_wbs - wbs_before);
			bench_errors++;
		end
		test_count++;
		$display("test %0d %s: %0d instructions, %0d errors", test_count, name, words,
			chk_errors + bench_errors - errs_before);
	endtask

	initial begin
		i_rst         <= 1'b1;
		i_instr       <= '0;
		i_instr_empty <= 1'b1;
		repeat (4) @(posedge CLK);
		i_rst <= 1'b0;

		fifo_q.push_back(imm_word(OP_LUI, 3'd1, 3'd0, 16'h1234));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd1, 3'd1, 16'h5678));
		fifo_q.push_back(imm_word(OP_LUI, 3'd2, 3'd0, 16'hf0f0));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd2, 3'd2, 16'hfffd));
		fifo_q.push_back(r_type_word(OP_ADD, 3'd3, 3'd1, 3'd2));
		fifo_q.push_back(r_type_word(OP_SUB, 3'd4, 3'd1, 3'd2));
		fifo_q.push_back(r_type_word(OP_AND, 3'd5, 3'd1, 3'd2));
		fifo_q.push_back(r_type_word(OP_OR, 3'd6, 3'd1, 3'd2));
		fifo_q.push_back(r_type_word(OP_XOR, 3'd7, 3'd1, 3'd2));
		fifo_q.push_back(r_type_word(OP_SLL, 3'd3, 3'd1, 3'd2));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd4, 3'd0, 16'hffff));
		fifo_q.push_back(r_type_word(OP_SLL, 3'd5, 3'd4, 3'd1));
		fifo_q.push_back(r_type_word(OP_SUB, 3'd6, 3'd0, 3'd1));
		run_queue("opcodes", 1'b0);

		fifo_q.push_back(imm_word(OP_LUI, 3'd0, 3'd0, 16'habcd));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd0, 3'd0, 16'h0005));
		fifo_q.push_back(r_type_word(OP_ADD, 3'd1, 3'd0, 3'd0));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd3, 3'd0, 16'h0007));
		fifo_q.push_back(r_type_word(OP_OR, 3'd2, 3'd0, 3'd3));
		fifo_q.push_back(r_type_word(OP_XOR, 3'd4, 3'd3, 3'd0));
		fifo_q.push_back(r_type_word(OP_SUB, 3'd5, 3'd0, 3'd3));
		run_queue("register zero", 1'b0);

		// every word depends on the one before
		fifo_q.push_back(imm_word(OP_ADDI, 3'd1, 3'd0, 16'h0001));
		repeat (10) fifo_q.push_back(r_type_word(OP_ADD, 3'd1, 3'd1, 3'd1));
		fifo_q.push_back(imm_word(OP_ADDI, 3'd2, 3'd1, 16'hffff));
		fifo_q.push_back(r_type_word(OP_XOR, 3'd3, 3'd2, 3'd1));
		run_queue("dependent chain", 1'b0);

		for (int i = 0; i < GAP_WORDS; i++)
			fifo_q.push_back(random_word());
		run_queue("empty gaps", 1'b1);

		for (int i = 0; i < RAND_WORDS; i++)
			fifo_q.push_back(random_word());
		run_queue("random stream", 1'b0);

		$display("summary: %0d tests, %0d pops, %0d writebacks, %0d errors", test_count,
			chk_pops, chk_wbs, chk_errors + bench_errors);
		if (chk_errors + bench_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

// File: backend.f
+incdir+verilog
verilog/backend_pkg.sv
verilog/backend_if.sv
verilog/dispatch.sv
verilog/alu_exe.sv
verilog/writeback.sv
verilog/backend.sv
bench/backend_check.sv
bench/backend_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
	-f backend.f \
	--top-module backend_tb \
	-o backend_sim

./obj_dir/backend_sim | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
